// ==== Makefile ====
TOP = icache_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module $(TOP) -f build.f -o sim

run: compile
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir

// ==== build.f ====
design/icache_pkg.sv
design/icache_line_ram.sv
design/icache_refill_buffer.sv
design/icache_ctrl.sv
design/icache_top.sv
dv/icache_props.sv
dv/icache_tb.sv

// ==== design/icache_ctrl.sv ====
`timescale 1ns/1ns

module icache_ctrl
    import icache_pkg::*;
(
    input  logic    clk,
    input  logic    rst,

    // Fetch side
    input  logic    ien,
    input  addr_t   iaddr,
    input  logic    uncached,
    input  logic    hit_invalidate,
    input  logic    index_invalidate,
    output logic    inst_ok,
    output logic    inst_ok_1,
    output logic    inst_ok_2,
    output word_t   inst_data_1,
    output word_t   inst_data_2,
    output logic    busy,

    // Memory side
    output addr_t   req_addr,
    output logic    req_en,
    output logic    req_uncached,
    input  logic    req_ok,
    input  word_t   rdata,
    input  logic    rvalid,
    input  logic    rlast,

    // Line memory
    output logic    ram_we,
    output index_t  ram_index,
    output tag_t    ram_tag,
    input  tag_t    rd_tag,
    input  line_t   rd_line,

    // Refill buffer
    output logic    buf_start,
    output logic    buf_beat,
    input  line_t   buf_line
);

    ctrl_state_t      state;
    ctrl_state_t      state_nxt;
    logic [LINES-1:0] valid;

    tag_t    tag;
    index_t  index;
    offset_t offset;
    addr_t   line_addr;

    logic    tag_match;
    logic    hit;
    logic    inval_req;
    logic    clear_valid;
    logic    last_word;

    line_t   pair_src;
    logic    pair_en;

    function automatic word_t pick_word(line_t l, offset_t off);
        return l[off*$bits(word_t) +: $bits(word_t)];
    endfunction

    assign tag    = iaddr[TAG_LSB +: $bits(tag_t)];
    assign index  = iaddr[INDEX_LSB +: $bits(index_t)];
    assign offset = iaddr[OFFSET_LSB +: $bits(offset_t)];

    assign line_addr = iaddr & ~addr_t'(LINE_BYTES - 1);  // Aligned refill address
    assign last_word = &offset;

    assign ram_index = index;
    assign ram_tag   = tag;

    assign tag_match = (rd_tag == tag);
    assign hit       = tag_match && valid[index];

    // Invalidate strobes win over a fetch in idle
    assign inval_req   = (state == IDLE) && ien && (hit_invalidate || index_invalidate);
    assign clear_valid = inval_req && (index_invalidate || (hit_invalidate && tag_match));

    assign ram_we   = (state == CACHED_REFILL);
    assign buf_beat = (state == CACHED_WAIT) && rvalid;
    assign busy     = (state != IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (state == CACHED_REFILL) begin
            valid[index] <= 1'b1;
        end else if (clear_valid) begin
            valid[index] <= 1'b0;
        end
    end

    // Hit pair comes from the memory, refill pair from the buffer
    assign pair_src = (state == CACHED_REFILL) ? buf_line : rd_line;
    assign pair_en  = (state == CACHED_REFILL)
                   || ((state == IDLE) && ien && !inval_req && !uncached && hit);

    always_comb begin
        state_nxt    = state;
        inst_ok      = 1'b0;
        inst_ok_1    = 1'b0;
        inst_ok_2    = 1'b0;
        inst_data_1  = '0;
        inst_data_2  = '0;
        req_en       = 1'b0;
        req_addr     = '0;
        req_uncached = 1'b0;
        buf_start    = 1'b0;

        if (pair_en) begin
            inst_ok     = 1'b1;
            inst_ok_1   = 1'b1;
            inst_ok_2   = !last_word;
            inst_data_1 = pick_word(pair_src, offset);
            if (!last_word) begin
                inst_data_2 = pick_word(pair_src, offset + 1'b1);
            end
        end

        case (state)
            IDLE: begin
                if (ien && !inval_req) begin
                    if (uncached) begin
                        req_en       = 1'b1;
                        req_addr     = iaddr;
                        req_uncached = 1'b1;
                        state_nxt    = req_ok ? UNCACHED_RETURN : UNCACHED_SHAKE;
                    end else if (!hit) begin
                        req_en    = 1'b1;
                        req_addr  = line_addr;
                        buf_start = req_ok;
                        state_nxt = req_ok ? CACHED_WAIT : CACHED_SHAKE;
                    end
                end
            end
            CACHED_SHAKE: begin
                req_en    = 1'b1;
                req_addr  = line_addr;
                buf_start = req_ok;
                if (req_ok) begin
                    state_nxt = CACHED_WAIT;
                end
            end
            CACHED_WAIT: begin
                if (rvalid && rlast) begin
                    state_nxt = CACHED_REFILL;
                end
            end
            CACHED_REFILL: begin
                state_nxt = IDLE;  // Pair already driven above
            end
            UNCACHED_SHAKE: begin
                req_en       = 1'b1;
                req_addr     = iaddr;
                req_uncached = 1'b1;
                if (req_ok) begin
                    state_nxt = UNCACHED_RETURN;
                end
            end
            UNCACHED_RETURN: begin
                // One instruction per beat
                inst_ok   = rvalid;
                inst_ok_1 = rvalid;
                if (rvalid) begin
                    inst_data_1 = rdata;
                end
                if (rvalid && rlast) begin
                    state_nxt = IDLE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

endmodule

// ==== design/icache_line_ram.sv ====
`timescale 1ns/1ns

module icache_line_ram
    import icache_pkg::*;
(
    input  logic   clk,
    input  logic   wr_en,
    input  index_t index,
    input  tag_t   wr_tag,
    input  line_t  wr_line,
    output tag_t   rd_tag,
    output line_t  rd_line
);

    // Tag and data kept side by side, one entry per line
    tag_t  tag_mem  [LINES];
    line_t data_mem [LINES];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[index]  <= wr_tag;
            data_mem[index] <= wr_line;
        end
    end

    // Asynchronous read, same index as the write port
    assign rd_tag  = tag_mem[index];
    assign rd_line = data_mem[index];

endmodule

// ==== design/icache_pkg.sv ====
package icache_pkg;

    // Cache geometry
    localparam int LINES      = 128;
    localparam int LINE_WORDS = 16;
    localparam int LINE_BYTES = 64;

    // Address field positions
    localparam int OFFSET_LSB = 2;
    localparam int INDEX_LSB  = 6;
    localparam int TAG_LSB    = 13;

    typedef logic [31:0]  addr_t;
    typedef logic [31:0]  word_t;
    typedef logic [18:0]  tag_t;     // addr[31:13]
    typedef logic [6:0]   index_t;   // addr[12:6]
    typedef logic [3:0]   offset_t;  // addr[5:2]
    typedef logic [511:0] line_t;    // Word 0 in the low bits

    typedef enum logic [2:0] {
        IDLE            = 3'b000,
        CACHED_SHAKE    = 3'b001,
        CACHED_WAIT     = 3'b010,
        CACHED_REFILL   = 3'b011,
        UNCACHED_SHAKE  = 3'b101,
        UNCACHED_RETURN = 3'b110
    } ctrl_state_t;

endpackage

// ==== design/icache_refill_buffer.sv ====
`timescale 1ns/1ns

module icache_refill_buffer
    import icache_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  start,
    input  logic  beat,
    input  word_t rdata,
    output line_t line
);

    offset_t cnt;                 // Slot for the next beat
    word_t   words [LINE_WORDS];

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (start) begin
            cnt <= '0;
        end else if (beat) begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < LINE_WORDS; i++) begin
                words[i] <= '0;
            end
        end else if (beat) begin
            words[cnt] <= rdata;
        end
    end

    // Pack into line layout, word 0 lowest
    always_comb begin
        line = '0;
        for (int i = 0; i < LINE_WORDS; i++) begin
            line[i*$bits(word_t) +: $bits(word_t)] = words[i];
        end
    end

endmodule

// ==== design/icache_top.sv ====
`timescale 1ns/1ns

module icache_top
    import icache_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    input  logic  ien,
    input  addr_t iaddr,
    input  logic  uncached,
    input  logic  hit_invalidate,
    input  logic  index_invalidate,
    output logic  inst_ok,
    output logic  inst_ok_1,
    output logic  inst_ok_2,
    output word_t inst_data_1,
    output word_t inst_data_2,
    output logic  busy,

    output addr_t req_addr,
    output logic  req_en,
    output logic  req_uncached,
    input  logic  req_ok,
    input  word_t rdata,
    input  logic  rvalid,
    input  logic  rlast
);

    logic   ram_we;
    index_t ram_index;
    tag_t   ram_tag;
    tag_t   rd_tag;
    line_t  rd_line;

    logic   buf_start;
    logic   buf_beat;
    line_t  buf_line;

    icache_ctrl i_ctrl (
        .clk              (clk),
        .rst              (rst),
        .ien              (ien),
        .iaddr            (iaddr),
        .uncached         (uncached),
        .hit_invalidate   (hit_invalidate),
        .index_invalidate (index_invalidate),
        .inst_ok          (inst_ok),
        .inst_ok_1        (inst_ok_1),
        .inst_ok_2        (inst_ok_2),
        .inst_data_1      (inst_data_1),
        .inst_data_2      (inst_data_2),
        .busy             (busy),
        .req_addr         (req_addr),
        .req_en           (req_en),
        .req_uncached     (req_uncached),
        .req_ok           (req_ok),
        .rdata            (rdata),
        .rvalid           (rvalid),
        .rlast            (rlast),
        .ram_we           (ram_we),
        .ram_index        (ram_index),
        .ram_tag          (ram_tag),
        .rd_tag           (rd_tag),
        .rd_line          (rd_line),
        .buf_start        (buf_start),
        .buf_beat         (buf_beat),
        .buf_line         (buf_line)
    );

    icache_line_ram i_line_ram (
        .clk     (clk),
        .wr_en   (ram_we),
        .index   (ram_index),
        .wr_tag  (ram_tag),
        .wr_line (buf_line),  // Refill data straight from the buffer
        .rd_tag  (rd_tag),
        .rd_line (rd_line)
    );

    icache_refill_buffer i_refill_buffer (
        .clk   (clk),
        .rst   (rst),
        .start (buf_start),
        .beat  (buf_beat),
        .rdata (rdata),
        .line  (buf_line)
    );

endmodule

// ==== dv/icache_props.sv ====
`timescale 1ns/1ns

module icache_props
    import icache_pkg::*;
(
    input logic  clk,
    input logic  rst,
    input logic  req_en,
    input logic  req_ok,
    input addr_t req_addr,
    input logic  inst_ok_1,
    input logic  inst_ok_2,
    input logic  busy
);

    int fail_count = 0;  // Assertion failures so far

    // Request must wait for its acknowledge unchanged
    a_req_held: assert property (
        @(posedge clk) disable iff (rst)
        (req_en && !req_ok) |=> (req_en && $stable(req_addr))
    ) else begin
        fail_count++;
        $error("req_en dropped or req_addr changed before req_ok");
    end

    a_ok2_needs_ok1: assert property (
        @(posedge clk) disable iff (rst)
        inst_ok_2 |-> inst_ok_1
    ) else begin
        fail_count++;
        $error("inst_ok_2 high without inst_ok_1");
    end

    a_idle_after_reset: assert property (
        @(posedge clk) $fell(rst) |-> !busy
    ) else begin
        fail_count++;
        $error("busy high in the first cycle after reset");
    end

endmodule

bind icache_top icache_props i_props (
    .clk       (clk),
    .rst       (rst),
    .req_en    (req_en),
    .req_ok    (req_ok),
    .req_addr  (req_addr),
    .inst_ok_1 (inst_ok_1),
    .inst_ok_2 (inst_ok_2),
    .busy      (busy)
);

// ==== dv/icache_tb.sv ====
`timescale 1ns/1ns

module icache_tb
    import icache_pkg::*;
();

    localparam int    CLK_PERIOD      = 40;
    localparam int    DRIVE_DELAY     = 2;
    localparam int    RESET_CYCLES    = 4;
    localparam int    CYCLES_PER_TEST = 60;
    localparam word_t WORD_MASK       = 32'h5a5a_0000;

    typedef enum logic [1:0] {OP_FETCH, OP_HIT_INVAL, OP_INDEX_INVAL} op_t;

    typedef struct packed {
        op_t   op;
        addr_t addr;
        logic  unc;
        logic  exp_req;  // Memory request must come out
    } entry_t;

    logic  clk;
    logic  rst;
    logic  ien;
    addr_t iaddr;
    logic  uncached;
    logic  hit_invalidate;
    logic  index_invalidate;
    logic  inst_ok;
    logic  inst_ok_1;
    logic  inst_ok_2;
    word_t inst_data_1;
    word_t inst_data_2;
    logic  busy;
    addr_t req_addr;
    logic  req_en;
    logic  req_uncached;
    logic  req_ok;
    word_t rdata;
    logic  rvalid;
    logic  rlast;

    entry_t      tests[$];
    addr_t       req_log_addr[$];
    logic        req_log_unc[$];
    logic [31:0] lfsr;
    logic        table_ready;
    int          errors;
    int          checks;

    icache_top i_dut (
        .clk              (clk),
        .rst              (rst),
        .ien              (ien),
        .iaddr            (iaddr),
        .uncached         (uncached),
        .hit_invalidate   (hit_invalidate),
        .index_invalidate (index_invalidate),
        .inst_ok          (inst_ok),
        .inst_ok_1        (inst_ok_1),
        .inst_ok_2        (inst_ok_2),
        .inst_data_1      (inst_data_1),
        .inst_data_2      (inst_data_2),
        .busy             (busy),
        .req_addr         (req_addr),
        .req_en           (req_en),
        .req_uncached     (req_uncached),
        .req_ok           (req_ok),
        .rdata            (rdata),
        .rvalid           (rvalid),
        .rlast            (rlast)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic int rand_bits(int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_bit());
        end
        return v;
    endfunction

    function automatic word_t expected_word(addr_t a);
        return a ^ WORD_MASK;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic check_equal(string what, logic [31:0] got, logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic add_entry(op_t op, addr_t a, logic unc, logic exp_req);
        entry_t e;
        e.op      = op;
        e.addr    = a;
        e.unc     = unc;
        e.exp_req = exp_req;
        tests.push_back(e);
    endtask

    task automatic fill_table();
        add_entry(OP_FETCH,       32'h0001_2344, 1'b0, 1'b1);  // Cold miss
        add_entry(OP_FETCH,       32'h0001_2344, 1'b0, 1'b0);
        add_entry(OP_FETCH,       32'h0001_237c, 1'b0, 1'b0);  // Last word of line
        add_entry(OP_FETCH,       32'h0004_0a08, 1'b1, 1'b1);
        add_entry(OP_FETCH,       32'h0004_0a08, 1'b0, 1'b1);  // Uncached left no line
        add_entry(OP_FETCH,       32'h0004_0a0c, 1'b0, 1'b0);
        add_entry(OP_HIT_INVAL,   32'h0001_2344, 1'b0, 1'b0);
        add_entry(OP_FETCH,       32'h0001_2350, 1'b0, 1'b1);
        add_entry(OP_HIT_INVAL,   32'h0001_4344, 1'b0, 1'b0);  // Other tag at the same index
        add_entry(OP_FETCH,       32'h0001_2348, 1'b0, 1'b0);
        add_entry(OP_INDEX_INVAL, 32'h0003_4344, 1'b0, 1'b0);
        add_entry(OP_FETCH,       32'h0001_2340, 1'b0, 1'b1);
        add_entry(OP_FETCH,       32'h0005_237c, 1'b0, 1'b1);  // Replaces the line
        add_entry(OP_FETCH,       32'h0001_2344, 1'b0, 1'b1);
        add_entry(OP_FETCH,       32'h0005_2340, 1'b0, 1'b1);
        add_entry(OP_FETCH,       32'h0000_1000, 1'b1, 1'b1);
        add_entry(OP_FETCH,       32'h0000_1ffc, 1'b0, 1'b1);
        add_entry(OP_FETCH,       32'h0000_1fc0, 1'b0, 1'b0);
    endtask

    task automatic drive_inputs(logic en, addr_t a, logic unc, logic hinv, logic xinv);
        ien              = en;
        iaddr            = a;
        uncached         = unc;
        hit_invalidate   = hinv;
        index_invalidate = xinv;
    endtask

    task automatic run_invalidate(entry_t e);
        drive_inputs(1'b1, e.addr, 1'b0, e.op == OP_HIT_INVAL, e.op == OP_INDEX_INVAL);
        @(negedge clk);
        check_equal("inst_ok on invalidate", 32'(inst_ok), 32'd0);
        check_equal("req_en on invalidate", 32'(req_en), 32'd0);
    endtask

    task automatic run_fetch(entry_t e);
        int    n_before;
        logic  saw_busy;
        logic  last;
        addr_t word_addr;
        n_before  = req_log_addr.size();
        saw_busy  = 1'b0;
        word_addr = {e.addr[31:2], 2'b00};
        last      = (e.addr[5:2] == 4'hf);
        drive_inputs(1'b1, e.addr, e.unc, 1'b0, 1'b0);
        @(negedge clk);
        while (!inst_ok) begin
            saw_busy |= busy;
            @(negedge clk);
        end
        saw_busy |= busy;
        check_equal("inst_ok_1", 32'(inst_ok_1), 32'd1);
        if (e.unc) begin
            check_equal("inst_data_1", inst_data_1, expected_word(e.addr));
            check_equal("inst_ok_2", 32'(inst_ok_2), 32'd0);
            check_equal("inst_data_2", inst_data_2, 32'd0);
        end else begin
            check_equal("inst_data_1", inst_data_1, expected_word(word_addr));
            check_equal("inst_ok_2", 32'(inst_ok_2), 32'(!last));
            check_equal("inst_data_2", inst_data_2,
                        last ? 32'd0 : expected_word(word_addr + 32'd4));
        end
        check_equal("busy seen", 32'(saw_busy), 32'(e.exp_req));
        check_equal("request count", req_log_addr.size(), n_before + int'(e.exp_req));
        if (e.exp_req && req_log_addr.size() == n_before + 1) begin
            check_equal("req_addr", req_log_addr[n_before],
                        e.unc ? e.addr : (e.addr & ~32'h3f));
            check_equal("req_uncached", 32'(req_log_unc[n_before]), 32'(e.unc));
        end
    endtask

    // Memory side model
    initial begin : responder
        int    beats;
        addr_t base;
        logic  kind;
        lfsr   = 32'hb90c_2968;
        req_ok = 1'b0;
        rvalid = 1'b0;
        rlast  = 1'b0;
        rdata  = '0;
        forever begin
            @(negedge clk);
            if (req_en && !rst) begin
                repeat (rand_bits(2) + 1) next_cycle();
                req_ok = 1'b1;
                @(negedge clk);
                base = req_addr;
                kind = req_uncached;
                req_log_addr.push_back(base);
                req_log_unc.push_back(kind);
                next_cycle();
                req_ok = 1'b0;
                beats  = kind ? 1 : LINE_WORDS;
                for (int b = 0; b < beats; b++) begin
                    if (rand_bits(1) == 1) next_cycle();  // Gap in rvalid
                    rvalid = 1'b1;
                    rlast  = (b == beats - 1);
                    rdata  = expected_word(base + addr_t'(4 * b));
                    next_cycle();
                    rvalid = 1'b0;
                    rlast  = 1'b0;
                    rdata  = '0;
                end
            end
        end
    end

    initial begin : stimulus
        errors      = 0;
        checks      = 0;
        table_ready = 1'b0;
        rst         = 1'b1;
        drive_inputs(1'b0, '0, 1'b0, 1'b0, 1'b0);
        fill_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY rst = 1'b0;
        foreach (tests[i]) begin
            next_cycle();
            if (tests[i].op == OP_FETCH) begin
                run_fetch(tests[i]);
            end else begin
                run_invalidate(tests[i]);
            end
        end
        next_cycle();
        drive_inputs(1'b0, '0, 1'b0, 1'b0, 1'b0);
        repeat (2) next_cycle();
        errors += i_dut.i_props.fail_count;  // Protocol property failures
        $display("Done: %0d tests, %0d checks, %0d errors", tests.size(), checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin : watchdog
        wait (table_ready);
        #(tests.size() * CYCLES_PER_TEST * CLK_PERIOD);
        $display("Timeout: the run did not finish in time, %0d errors so far", errors);
        $display("Something failed");
        $finish;
    end

endmodule
